/* verilog/hss_link_pkg.sv */
package hss_link_pkg;

	//////////////////////////////////////////////////////////////////////////
	// 8b/10b control characters
	//////////////////////////////////////////////////////////////////////////

	// K28.5, the only comma in use, always the first byte of an aligned frame
	localparam logic [7:0]  kch_comma     = 8'hBC;
	// K28.3 marks a handshake word
	localparam logic [7:0]  kch_handshake = 8'h7C;
	// K28.0, repeated four times for clock correction
	localparam logic [7:0]  kch_clkc      = 8'h1C;
	// comma followed by K28.1 heads every idle frame
	localparam logic [15:0] kch_idle      = 16'hBC3C;

	//////////////////////////////////////////////////////////////////////////
	// link protocol
	//////////////////////////////////////////////////////////////////////////

	// version carried in the low byte of every handshake
	localparam logic [7:0] protocol_version = 8'h01;

	// idle sentinel occupies the low half of an idle frame
	localparam int idle_bits = 16;

	// K flag patterns, lane 0 in the msb
	localparam logic [3:0] handshake_kbits = 4'b1100;
	localparam logic [3:0] idle_kbits      = 4'b1100;
	localparam logic [3:0] clkc_kbits      = 4'b1111;

	// transceiver loss-of-sync codes (2'b11 is never expected)
	localparam logic [1:0] los_synced = 2'b00;
	localparam logic [1:0] los_resync = 2'b01;
	localparam logic [1:0] los_lost   = 2'b10;

	// resync cycles the tile waits before it reports sync again
	localparam int num_clkc_for_sync = 4;

endpackage

/* verilog/hss_los_tracker.sv */
`timescale 1ns/1ps

module hss_los_tracker
	import hss_link_pkg::*;
(
	input  logic       CLK_IN,
	input  logic       RESET_IN,
	input  logic [1:0] rx_loss_of_sync_i,
	output logic       byte_aligned_o
);

	typedef enum logic [1:0]
	{
		st_lost,
		st_resync,
		st_synced
	} los_state_t;

	localparam int cnt_bits = $clog2(num_clkc_for_sync + 2);

	los_state_t          state;
	// cycles spent in resync with the resync code still present
	logic [cnt_bits-1:0] resync_cnt;

	// counter only runs while resync is held in the resync state
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			resync_cnt <= '0;
		else if (state == st_resync && rx_loss_of_sync_i == los_resync)
			resync_cnt <= resync_cnt + 1'b1;
		else
			resync_cnt <= '0;
	end

	// same rule as the tile, sync only after the resync period has elapsed
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			state <= st_lost;
		else
		begin
			case (rx_loss_of_sync_i)
				los_synced:
					state <= st_synced;
				los_resync:
				begin
					if (state == st_lost)
						state <= st_resync;
					else if (state == st_resync && resync_cnt >= num_clkc_for_sync)
						state <= st_synced;
				end
				// lost, and the invalid code as well
				default:
					state <= st_lost;
			endcase
		end
	end

	assign byte_aligned_o = (state == st_synced);

endmodule

/* verilog/hss_word_aligner.sv */
`timescale 1ns/1ps

module hss_word_aligner
(
	input  logic        CLK_IN,
	input  logic        RESET_IN,
	input  logic [31:0] rx_data_i,
	input  logic [3:0]  rx_char_is_comma_i,
	input  logic [3:0]  rx_char_is_k_i,
	input  logic        byte_aligned_i,
	output logic [31:0] aligned_data_o,
	output logic [3:0]  aligned_k_o,
	output logic        word_aligned_o
);

	// previous cycle's word, needed when a frame straddles two cycles
	logic [31:0] prev_data;
	logic [3:0]  prev_k;

	// lane of the last comma seen, lane 0 is the top byte
	logic [1:0]  comma_lane;
	logic        comma_seen;
	logic [1:0]  comma_idx;

	// two words back to back, older one on top
	logic [63:0] data_window;
	logic [7:0]  k_window;

	always_ff @(posedge CLK_IN)
	begin
		prev_data <= rx_data_i;
		prev_k    <= rx_char_is_k_i;
	end

	// first flagged lane wins, flag bit 3 belongs to lane 0
	always_comb
	begin
		if (rx_char_is_comma_i[3])
			comma_idx = 2'd0;
		else if (rx_char_is_comma_i[2])
			comma_idx = 2'd1;
		else if (rx_char_is_comma_i[1])
			comma_idx = 2'd2;
		else
			comma_idx = 2'd3;
	end

	// commas only mean something once the byte stream is aligned
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
		begin
			comma_lane <= 2'd0;
			comma_seen <= 1'b0;
		end
		else if (!byte_aligned_i)
		begin
			comma_lane <= 2'd0;
			comma_seen <= 1'b0;
		end
		else if (rx_char_is_comma_i != 4'b0000)
		begin
			comma_lane <= comma_idx;
			comma_seen <= 1'b1;
		end
	end

	assign data_window = {prev_data, rx_data_i};
	assign k_window    = {prev_k, rx_char_is_k_i};

	// lanes L..3 of the old word, then lanes 0..L-1 of the new one
	always_comb
	begin
		case (comma_lane)
			2'd0:
			begin
				aligned_data_o = data_window[63:32];
				aligned_k_o    = k_window[7:4];
			end
			2'd1:
			begin
				aligned_data_o = data_window[55:24];
				aligned_k_o    = k_window[6:3];
			end
			2'd2:
			begin
				aligned_data_o = data_window[47:16];
				aligned_k_o    = k_window[5:2];
			end
			default:
			begin
				aligned_data_o = data_window[39:8];
				aligned_k_o    = k_window[4:1];
			end
		endcase
	end

	assign word_aligned_o = byte_aligned_i && comma_seen;

endmodule

/* verilog/hss_rx_control.sv */
`timescale 1ns/1ps

module hss_rx_control
	import hss_link_pkg::*;
#(
	// consecutive good handshakes before moving on to phase 1
	parameter int num_handshakes_p = 100
)
(
	input  logic                 CLK_IN,
	input  logic                 RESET_IN,
	// aligned stream from the word aligner
	input  logic [31:0]          aligned_data_i,
	input  logic [3:0]           aligned_k_i,
	input  logic                 word_aligned_i,
	// handshake status, phase goes to the tx side
	output logic                 handshake_phase_o,
	output logic                 handshake_complete_o,
	output logic                 version_mismatch_o,
	// sentinel of the last idle frame from the remote end
	output logic [idle_bits-1:0] reg_idsi_o,
	// user words with all link frames removed
	output logic [31:0]          rx_word_o,
	output logic [3:0]           rx_word_k_o,
	output logic                 rx_vld_o
);

	localparam int hs_cnt_bits = $clog2(num_handshakes_p + 1);

	logic                   is_idle;
	logic                   is_clkc;
	logic                   is_handshake;
	logic                   rx_phase;
	logic                   bad_version;
	logic                   last_phase;
	logic                   restart;
	logic [hs_cnt_bits-1:0] hs_cnt;
	logic                   pass_word;

	//////////////////////////////////////////////////////////////////////////
	// frame classification
	//////////////////////////////////////////////////////////////////////////

	assign is_idle = word_aligned_i
		&& aligned_data_i[31:16] == kch_idle
		&& aligned_k_i == idle_kbits;

	assign is_clkc = word_aligned_i
		&& aligned_data_i == {4{kch_clkc}}
		&& aligned_k_i == clkc_kbits;

	// comma, handshake K-char, phase byte, version byte
	assign is_handshake = word_aligned_i
		&& aligned_data_i[31:24] == kch_comma
		&& aligned_data_i[23:16] == kch_handshake
		&& aligned_k_i == handshake_kbits;

	// only meaningful together with is_handshake
	assign rx_phase    = aligned_data_i[8];
	assign bad_version = aligned_data_i[7:0] != protocol_version;

	//////////////////////////////////////////////////////////////////////////
	// handshake
	//////////////////////////////////////////////////////////////////////////

	// remote side going back to phase 0 asks for a new handshake
	// a link that lost word alignment starts over from phase 0
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			last_phase <= 1'b0;
		else if (!word_aligned_i)
			last_phase <= 1'b0;
		else if (is_handshake)
			last_phase <= rx_phase;
	end

	assign restart = !word_aligned_i
		|| (is_handshake && !rx_phase && last_phase)
		|| (is_handshake && bad_version);

	// clock correction may sit between handshakes without breaking the run
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			hs_cnt <= '0;
		else if (is_handshake && !restart)
		begin
			if (!handshake_phase_o)
				hs_cnt <= hs_cnt + 1'b1;
		end
		else if (!is_clkc)
			hs_cnt <= '0;
	end

	assign handshake_phase_o = (hs_cnt == hs_cnt_bits'(num_handshakes_p));

	// we are in phase 1 and so is the remote end
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			handshake_complete_o <= 1'b0;
		else if (restart)
			handshake_complete_o <= 1'b0;
		else if (handshake_phase_o && is_handshake && rx_phase)
			handshake_complete_o <= 1'b1;
	end

	// one pulse per wrong-version handshake
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			version_mismatch_o <= 1'b0;
		else
			version_mismatch_o <= is_handshake && bad_version;
	end

	//////////////////////////////////////////////////////////////////////////
	// idle sentinel and output filter
	//////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			reg_idsi_o <= {idle_bits{1'b1}};
		else if (is_idle)
			reg_idsi_o <= aligned_data_i[idle_bits-1:0];
	end

	assign pass_word = word_aligned_i && handshake_complete_o
		&& !is_clkc && !is_handshake && !is_idle;

	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			rx_vld_o <= 1'b0;
		else
			rx_vld_o <= pass_word;
	end

	// word registers only load when a word is passed on
	always_ff @(posedge CLK_IN)
	begin
		if (pass_word)
		begin
			rx_word_o   <= aligned_data_i;
			rx_word_k_o <= aligned_k_i;
		end
	end

endmodule

/* verilog/hss_tx_control.sv */
`timescale 1ns/1ps

module hss_tx_control
	import hss_link_pkg::*;
#(
	// cycles from one clock-correction word to the next
	parameter int clkc_interval_p = 1000
)
(
	input  logic                 CLK_IN,
	input  logic                 RESET_IN,
	// handshake state from the rx side
	input  logic                 handshake_phase_i,
	input  logic                 handshake_complete_i,
	// offered user word
	input  logic [31:0]          tx_word_i,
	input  logic [3:0]           tx_word_k_i,
	input  logic                 tx_vld_i,
	// local idle sentinel
	input  logic [idle_bits-1:0] reg_idso_i,
	output logic                 tx_rdy_o,
	// to the transceiver
	output logic [31:0]          tx_data_o,
	output logic [3:0]           tx_char_is_k_o
);

	localparam int cnt_bits = (clkc_interval_p > 1) ? $clog2(clkc_interval_p) : 1;

	logic [cnt_bits-1:0] clkc_cnt;
	logic                clkc_due;
	logic [31:0]         next_data;
	logic [3:0]          next_k;

	//////////////////////////////////////////////////////////////////////////
	// clock-correction interval
	//////////////////////////////////////////////////////////////////////////

	// free running from reset, wraps every clkc_interval_p cycles
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			clkc_cnt <= '0;
		else if (clkc_due)
			clkc_cnt <= '0;
		else
			clkc_cnt <= clkc_cnt + 1'b1;
	end

	assign clkc_due = (clkc_cnt == cnt_bits'(clkc_interval_p - 1));

	// user data only goes out on a linked channel and never in a clkc slot
	assign tx_rdy_o = handshake_complete_i && !clkc_due;

	//////////////////////////////////////////////////////////////////////////
	// word selection
	//////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		if (clkc_due)
		begin
			next_data = {4{kch_clkc}};
			next_k    = clkc_kbits;
		end
		else if (!handshake_complete_i)
		begin
			// phase bit sits in bit 8, version in the low byte
			next_data = {kch_comma, kch_handshake, 7'b0, handshake_phase_i, protocol_version};
			next_k    = handshake_kbits;
		end
		else if (tx_vld_i)
		begin
			next_data = tx_word_i;
			next_k    = tx_word_k_i;
		end
		else
		begin
			// nothing to send, advertise our sentinel
			next_data = {kch_idle, reg_idso_i};
			next_k    = idle_kbits;
		end
	end

	// link starts out sending phase 0 handshakes
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
		begin
			tx_data_o      <= {kch_comma, kch_handshake, 8'h00, protocol_version};
			tx_char_is_k_o <= handshake_kbits;
		end
		else
		begin
			tx_data_o      <= next_data;
			tx_char_is_k_o <= next_k;
		end
	end

endmodule

/* verilog/hss_link_ctrl.sv */
`timescale 1ns/1ps

module hss_link_ctrl
	import hss_link_pkg::*;
#(
	parameter int num_handshakes_p = 100,
	parameter int clkc_interval_p  = 1000
)
(
	input  logic                 CLK_IN,
	input  logic                 RESET_IN,
	// transceiver receive side
	input  logic [31:0]          rx_data_i,
	input  logic [3:0]           rx_char_is_comma_i,
	input  logic [3:0]           rx_char_is_k_i,
	input  logic [1:0]           rx_loss_of_sync_i,
	// transceiver transmit side
	output logic [31:0]          tx_data_o,
	output logic [3:0]           tx_char_is_k_o,
	// user transmit words
	input  logic [31:0]          tx_word_i,
	input  logic [3:0]           tx_word_k_i,
	input  logic                 tx_vld_i,
	output logic                 tx_rdy_o,
	// sentinels, local out and remote in
	input  logic [idle_bits-1:0] reg_idso_i,
	output logic [idle_bits-1:0] reg_idsi_o,
	// user receive words
	output logic [31:0]          rx_word_o,
	output logic [3:0]           rx_word_k_o,
	output logic                 rx_vld_o,
	// link status
	output logic                 version_mismatch_o,
	output logic                 handshake_phase_o,
	output logic                 handshake_complete_o
);

	logic        byte_aligned;
	logic [31:0] aligned_data;
	logic [3:0]  aligned_k;
	logic        word_aligned;

	hss_los_tracker i_los_tracker
	(
		.CLK_IN            (CLK_IN),
		.RESET_IN          (RESET_IN),
		.rx_loss_of_sync_i (rx_loss_of_sync_i),
		.byte_aligned_o    (byte_aligned)
	);

	hss_word_aligner i_word_aligner
	(
		.CLK_IN             (CLK_IN),
		.RESET_IN           (RESET_IN),
		.rx_data_i          (rx_data_i),
		.rx_char_is_comma_i (rx_char_is_comma_i),
		.rx_char_is_k_i     (rx_char_is_k_i),
		.byte_aligned_i     (byte_aligned),
		.aligned_data_o     (aligned_data),
		.aligned_k_o        (aligned_k),
		.word_aligned_o     (word_aligned)
	);

	hss_rx_control #(
		.num_handshakes_p (num_handshakes_p)
	) i_rx_control
	(
		.CLK_IN               (CLK_IN),
		.RESET_IN             (RESET_IN),
		.aligned_data_i       (aligned_data),
		.aligned_k_i          (aligned_k),
		.word_aligned_i       (word_aligned),
		.handshake_phase_o    (handshake_phase_o),
		.handshake_complete_o (handshake_complete_o),
		.version_mismatch_o   (version_mismatch_o),
		.reg_idsi_o           (reg_idsi_o),
		.rx_word_o            (rx_word_o),
		.rx_word_k_o          (rx_word_k_o),
		.rx_vld_o             (rx_vld_o)
	);

	// tx follows the handshake state reported by the rx side
	hss_tx_control #(
		.clkc_interval_p (clkc_interval_p)
	) i_tx_control
	(
		.CLK_IN               (CLK_IN),
		.RESET_IN             (RESET_IN),
		.handshake_phase_i    (handshake_phase_o),
		.handshake_complete_i (handshake_complete_o),
		.tx_word_i            (tx_word_i),
		.tx_word_k_i          (tx_word_k_i),
		.tx_vld_i             (tx_vld_i),
		.reg_idso_i           (reg_idso_i),
		.tx_rdy_o             (tx_rdy_o),
		.tx_data_o            (tx_data_o),
		.tx_char_is_k_o       (tx_char_is_k_o)
	);

endmodule

/* bench/hss_link_asserts.sv */
`timescale 1ns/1ps

module hss_link_asserts
	import hss_link_pkg::*;
(
	input logic        CLK_IN,
	input logic        RESET_IN,
	input logic        rx_vld_o,
	input logic        handshake_complete_o,
	input logic        tx_rdy_o,
	input logic [31:0] tx_data_o,
	input logic [3:0]  tx_char_is_k_o
);

	// a user word can only come out of a linked channel
	a_vld_needs_link: assert property (
		@(posedge CLK_IN) disable iff (RESET_IN)
		rx_vld_o |-> handshake_complete_o
	) else $error("rx word valid while the handshake is not complete");

	// first cycle out of reset
	a_reset_quiet: assert property (
		@(posedge CLK_IN)
		$fell(RESET_IN) |-> (!rx_vld_o && !handshake_complete_o)
	) else $error("rx valid or handshake complete set right after reset");

	// the word chosen in a ready cycle shows up one cycle later
	a_no_rdy_in_clkc: assert property (
		@(posedge CLK_IN) disable iff (RESET_IN)
		tx_rdy_o |=> !(tx_data_o == {4{kch_clkc}} && tx_char_is_k_o == clkc_kbits)
	) else $error("tx ready was high in a clock-correction slot");

endmodule

bind hss_link_ctrl hss_link_asserts i_asserts (.*);

/* bench/hss_link_tb.sv */
`timescale 1ns/1ps

module hss_link_tb
	import hss_link_pkg::*;
;

	logic                 CLK_IN;
	logic                 RESET_IN;
	logic [31:0]          rx_data_i;
	logic [3:0]           rx_char_is_comma_i;
	logic [3:0]           rx_char_is_k_i;
	logic [1:0]           rx_loss_of_sync_i;
	logic [31:0]          tx_data_o;
	logic [3:0]           tx_char_is_k_o;
	logic [31:0]          tx_word_i;
	logic [3:0]           tx_word_k_i;
	logic                 tx_vld_i;
	logic                 tx_rdy_o;
	logic [idle_bits-1:0] reg_idso_i;
	logic [idle_bits-1:0] reg_idsi_o;
	logic [31:0]          rx_word_o;
	logic [3:0]           rx_word_k_o;
	logic                 rx_vld_o;
	logic                 version_mismatch_o;
	logic                 handshake_phase_o;
	logic                 handshake_complete_o;

	// stim record: kind, lane, k flags, arg, then the 32 bit word
	logic [47:0] stim_mem [0:127];
	// byte stream towards the dut, {comma, k, byte}
	logic [9:0]  byte_q[$];
	// expected rx words, {k, data}
	logic [35:0] exp_q[$];

	int     errors = 0;
	int     checks = 0;
	int     cur_lane = 0;
	int     mismatch_cnt = 0;
	int     rx_cnt = 0;
	int     tx_acc_cnt = 0;
	int     clkc_cnt = 0;
	int     clkc_gap = 0;
	integer seed = 59;

	// tx monitor state, sampled one cycle before the word shows up
	logic        tx_prev_valid = 1'b0;
	logic        tx_prev_complete;
	logic        tx_prev_phase;
	logic        tx_prev_acc = 1'b0;
	logic [31:0] tx_prev_word;
	logic [3:0]  tx_prev_k;
	logic        clkc_seen = 1'b0;
	logic        tx_is_clkc;
	logic [35:0] exp_word;

	hss_link_ctrl #(
		.num_handshakes_p (8),
		.clkc_interval_p  (16)
	) i_dut (.*);

	always #5 CLK_IN = ~CLK_IN;

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0t: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	//////////////////////////////////////////////////////////////////////////
	// rx byte stream
	//////////////////////////////////////////////////////////////////////////

	task automatic push_byte(input logic [7:0] data, input logic k, input logic comma);
		byte_q.push_back({comma, k, data});
	endtask

	// pops four bytes, lane 0 in the top byte
	task automatic emit_word();
		logic [9:0] b;
		@(posedge CLK_IN);
		#1;
		for (int i = 0; i < 4; i++)
		begin
			b = byte_q.pop_front();
			rx_data_i[31-8*i -: 8] = b[7:0];
			rx_char_is_k_i[3-i]     = b[8];
			rx_char_is_comma_i[3-i] = b[9];
		end
	endtask

	// clkc bytes fill the gap when the frame moves to another lane
	// comma flag marks the first byte of every frame
	task automatic push_frame(input logic [31:0] word, input logic [3:0] k, input int lane);
		int pad;
		if (lane != cur_lane)
		begin
			pad = ((lane - cur_lane) & 3) + 4;
			repeat (pad)
				push_byte(kch_clkc, 1'b1, 1'b0);
			cur_lane = lane;
		end
		for (int i = 0; i < 4; i++)
			push_byte(word[31-8*i -: 8], k[3-i], i == 0);
		while (byte_q.size() >= 4)
			emit_word();
	endtask

	task automatic send_filler();
		push_frame({4{kch_clkc}}, clkc_kbits, cur_lane);
	endtask

	task automatic wait_level(input logic sel_phase, input logic want);
		int t;
		t = 0;
		while (((sel_phase ? handshake_phase_o : handshake_complete_o) != want) && t < 60)
		begin
			send_filler();
			t++;
		end
		if ((sel_phase ? handshake_phase_o : handshake_complete_o) != want)
		begin
			errors++;
			$display("timeout: handshake %s never reached %0d",
				sel_phase ? "phase" : "complete", want);
		end
	endtask

	task automatic drain_rx();
		int t;
		t = 0;
		while (exp_q.size() != 0 && t < 60)
		begin
			send_filler();
			t++;
		end
		if (exp_q.size() != 0)
		begin
			errors++;
			$display("timeout: %0d expected rx words never arrived", exp_q.size());
		end
	endtask

	//////////////////////////////////////////////////////////////////////////
	// monitors
	//////////////////////////////////////////////////////////////////////////

	always @(negedge CLK_IN)
	begin
		if (!RESET_IN && rx_vld_o)
		begin
			rx_cnt++;
			if (exp_q.size() == 0)
			begin
				errors++;
				$display("unexpected rx word %h at %0t", rx_word_o, $time);
			end
			else
			begin
				exp_word = exp_q.pop_front();
				check("rx word", rx_word_o, exp_word[31:0]);
				check("rx word k", 32'(rx_word_k_o), 32'(exp_word[35:32]));
			end
		end
		if (!RESET_IN && version_mismatch_o)
			mismatch_cnt++;
	end

	// tx word predicted from the state of the previous cycle
	always @(negedge CLK_IN)
	begin
		if (tx_prev_valid)
		begin
			tx_is_clkc = (tx_data_o == {4{kch_clkc}}) && (tx_char_is_k_o == clkc_kbits);
			// one clkc every 16 words
			if (clkc_seen)
				check("clkc slot", 32'(tx_is_clkc), 32'(clkc_gap == 16));
			if (tx_is_clkc)
			begin
				check("tx word accepted in clkc slot", 32'(tx_prev_acc), 32'd0);
				clkc_seen = 1'b1;
				clkc_gap  = 0;
				clkc_cnt++;
			end
			else if (!tx_prev_complete)
			begin
				check("tx handshake", tx_data_o,
					{kch_comma, kch_handshake, 7'b0, tx_prev_phase, protocol_version});
				check("tx handshake k", 32'(tx_char_is_k_o), 32'(handshake_kbits));
				check("tx word accepted during handshake", 32'(tx_prev_acc), 32'd0);
			end
			else if (tx_prev_acc)
			begin
				check("tx data", tx_data_o, tx_prev_word);
				check("tx data k", 32'(tx_char_is_k_o), 32'(tx_prev_k));
				tx_acc_cnt++;
			end
			else
			begin
				check("tx idle", tx_data_o, {kch_idle, reg_idso_i});
				check("tx idle k", 32'(tx_char_is_k_o), 32'(idle_kbits));
			end
			clkc_gap++;
		end
		tx_prev_complete = handshake_complete_o;
		tx_prev_phase    = handshake_phase_o;
		tx_prev_acc      = tx_vld_i && tx_rdy_o;
		tx_prev_word     = tx_word_i;
		tx_prev_k        = tx_word_k_i;
		tx_prev_valid    = !RESET_IN;
	end

	// random tx offers, held until taken
	always @(posedge CLK_IN)
	begin
		#1;
		if (!RESET_IN && (!tx_vld_i || tx_prev_acc))
		begin
			tx_vld_i    = (($random(seed) & 3) != 0);
			tx_word_i   = 32'($random(seed));
			tx_word_k_i = 4'($random(seed));
		end
	end

	//////////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [47:0] rec;
		logic        done;
		CLK_IN             = 1'b0;
		RESET_IN           = 1'b1;
		rx_data_i          = '0;
		rx_char_is_comma_i = '0;
		rx_char_is_k_i     = '0;
		rx_loss_of_sync_i  = los_lost;
		tx_word_i          = '0;
		tx_word_k_i        = '0;
		tx_vld_i           = 1'b0;
		reg_idso_i         = 16'hA5C3;
		done               = 1'b0;
		$readmemh("bench/hss_link_stim.txt", stim_mem);
		repeat (5)
			@(posedge CLK_IN);
		#1;
		RESET_IN = 1'b0;

		for (int idx = 0; idx < 128 && !done; idx++)
		begin
			rec = stim_mem[idx];
			case (rec[47:44])
				4'h1:
					push_frame(rec[31:0], rec[39:36], int'(rec[43:40]));
				4'h2:
				begin
					exp_q.push_back({rec[39:36], rec[31:0]});
					push_frame(rec[31:0], rec[39:36], int'(rec[43:40]));
				end
				4'h3:
				begin
					// new loss-of-sync code held for a number of cycles
					rx_loss_of_sync_i = rec[33:32];
					repeat (int'(rec[7:0]))
						send_filler();
				end
				4'h4:
				begin
					repeat (6)
						send_filler();
					check("remote sentinel", 32'(reg_idsi_o), 32'(rec[15:0]));
				end
				4'h5:
					wait_level(rec[32], rec[0]);
				4'h6:
				begin
					// one more word so the monitor has counted the latest pulse
					send_filler();
					check("version mismatch pulses", 32'(mismatch_cnt), rec[31:0]);
				end
				4'h7:
					drain_rx();
				default:
					done = 1'b1;
			endcase
		end

		repeat (8)
			send_filler();
		check("rx words outstanding", 32'(exp_q.size()), 32'd0);
		check("tx words taken", 32'(tx_acc_cnt > 0), 32'd1);
		check("clkc words sent", 32'(clkc_cnt > 2), 32'd1);
		$display("checks %0d, errors %0d, rx words %0d, tx words %0d",
			checks, errors, rx_cnt, tx_acc_cnt);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* bench/hss_link_stim.txt */
// kind lane kbits arg word, one 12 digit hex value per record
// kind 1 link frame, 2 data expected on rx, 3 los code=arg cycles=word,
// kind 4 sentinel, 5 wait level (arg 1 phase, 0 complete), 6 mismatches, 7 drain, 0 end
40000000FFFF
300100000008
300000000000
10C0BC7C0001
10C0BC7C0001
10C0BC7C0001
10C0BC7C0001
10F01C1C1C1C
10C0BC7C0001
10C0BC7C0001
10C0BC7C0001
10C0BC7C0001
500100000001
10C0BC7C0101
500000000001
200011223344
10F01C1C1C1C
200055667788
10C0BC7C0101
10C0BC3CABCD
20009900AABB
22000BADF00D
228001234567
12C0BC3C5A5A
12F01C1C1C1C
12C0BC7C0101
2200CAFEBABE
700000000000
400000005A5A
12C0BC7C0002
500000000000
600000000001
120011111111
12C0BC7C0001
12C0BC7C0001
12C0BC7C0001
12C0BC7C0001
12C0BC7C0001
12C0BC7C0001
12C0BC7C0001
12C0BC7C0001
500100000001
12C0BC7C0101
500000000001
2200DEADBEEF
700000000000
300200000003
500000000000
120022222222
300100000008
300000000000
10C0BC7C0001
10C0BC7C0001
10C0BC7C0001
10C0BC7C0001
10C0BC7C0001
10C0BC7C0001
10C0BC7C0001
10C0BC7C0001
500100000001
10C0BC7C0101
500000000001
20000F0F0F0F
10C0BC3C7777
2000F0F0F0F0
700000000000
400000007777
600000000001
000000000000

/* src.f */
verilog/hss_link_pkg.sv
verilog/hss_los_tracker.sv
verilog/hss_word_aligner.sv
verilog/hss_rx_control.sv
verilog/hss_tx_control.sv
verilog/hss_link_ctrl.sv
bench/hss_link_asserts.sv
bench/hss_link_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = hss_link_tb
FILELIST  = src.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
